/* hw/div_pkg.sv */
// Opcode values follow the low two bits of the RISC-V M-extension funct3 encoding.
package div_pkg;

  // Default operand width. The top level overrides it through its parameter.
  parameter int DIV_DATA_WIDTH = 32;

  // Opcode written to CTRL[1:0].
  typedef enum logic [1:0] {
    DIV_OP_DIV  = 2'b00,
    DIV_OP_DIVU = 2'b01,
    DIV_OP_REM  = 2'b10,
    DIV_OP_REMU = 2'b11
  } div_op_e;

  // Iterative core state.
  typedef enum logic {
    DIV_IDLE = 1'b0,
    DIV_BUSY = 1'b1
  } div_state_e;

endpackage

/* hw/apb_pkg.sv */
// Register map for an 8-bit APB address space; only exact word offsets are decoded.
package apb_pkg;

  parameter int APB_ADDR_WIDTH = 8;

  // Register offsets.
  localparam logic [APB_ADDR_WIDTH-1:0] REG_OPA    = 8'h00;
  localparam logic [APB_ADDR_WIDTH-1:0] REG_OPB    = 8'h04;
  localparam logic [APB_ADDR_WIDTH-1:0] REG_CTRL   = 8'h08; // Opcode in bits 1:0.
  localparam logic [APB_ADDR_WIDTH-1:0] REG_STATUS = 8'h0C; // Bit 0 busy, bit 1 done.
  localparam logic [APB_ADDR_WIDTH-1:0] REG_RESULT = 8'h10;

  // Why an access is answered with pslverr.
  typedef enum logic [1:0] {
    ERR_NONE = 2'd0,
    ERR_BUSY = 2'd1, // Unit busy, or result not yet available.
    ERR_ADDR = 2'd2  // Unmapped offset.
  } apb_err_e;

endpackage

/* hw/div_apb_regs.sv */
// Zero-wait-state APB slave; one operation in flight, refused writes leave all state unchanged.
`timescale 1ns/1ns

module div_apb_regs #(
  parameter int DATA_WIDTH = div_pkg::DIV_DATA_WIDTH
) (
  input  logic                              clk,
  input  logic                              nrst,
  input  logic                              psel,
  input  logic                              penable,
  input  logic                              pwrite,
  input  logic [apb_pkg::APB_ADDR_WIDTH-1:0] paddr,
  input  logic [DATA_WIDTH-1:0]             pwdata,
  input  logic                              res_valid,
  input  logic [DATA_WIDTH-1:0]             result,
  output logic [DATA_WIDTH-1:0]             prdata,
  output logic                              pready,
  output logic                              pslverr,
  output logic                              start,
  output div_pkg::div_op_e                  op,
  output logic [DATA_WIDTH-1:0]             opa,
  output logic [DATA_WIDTH-1:0]             opb
);
  import div_pkg::*;
  import apb_pkg::*;

  logic                  access;
  logic                  wr_ok;
  logic                  busy;
  logic                  done;
  logic [DATA_WIDTH-1:0] result_q;
  apb_err_e              err;

  assign access = psel & penable;
  assign pready = 1'b1;

  // Classify the addressed register against the current unit state.
  always_comb begin
    err = ERR_NONE;
    case (paddr)
      REG_OPA, REG_OPB, REG_CTRL: if (pwrite && busy) err = ERR_BUSY;
      REG_STATUS: err = ERR_NONE; // Writes are ignored.
      REG_RESULT: if (!pwrite && !done) err = ERR_BUSY;
      default: err = ERR_ADDR;
    endcase
  end

  assign pslverr = access & (err != ERR_NONE);
  assign wr_ok   = access & pwrite & (err == ERR_NONE);
  assign start   = wr_ok & (paddr == REG_CTRL);
  assign op      = div_op_e'(pwdata[1:0]); // Sampled by the first stage on start.

  always_ff @(posedge clk) begin
    if (!nrst) begin
      busy <= 1'b0;
      done <= 1'b0;
    end else begin
      if (start) begin
        busy <= 1'b1;
        done <= 1'b0;
      end else if (res_valid) begin
        busy <= 1'b0;
        done <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_ok && paddr == REG_OPA) opa <= pwdata;
    if (wr_ok && paddr == REG_OPB) opb <= pwdata;
    if (res_valid) result_q <= result;
  end

  // Read data only during an accepted read access.
  always_comb begin
    prdata = '0;
    if (access && !pwrite && err == ERR_NONE) begin
      case (paddr)
        REG_OPA:    prdata = opa;
        REG_OPB:    prdata = opb;
        REG_STATUS: prdata = DATA_WIDTH'({done, busy});
        REG_RESULT: prdata = result_q;
        default:    prdata = '0;
      endcase
    end
  end

endmodule

/* hw/div_operand_prep.sv */
// First stage; operands are taken on start only, special cases are flagged, not resolved.
`timescale 1ns/1ns

module div_operand_prep #(
  parameter int DATA_WIDTH = div_pkg::DIV_DATA_WIDTH
) (
  input  logic                  clk,
  input  logic                  nrst,
  input  logic                  start,
  input  div_pkg::div_op_e      op,
  input  logic [DATA_WIDTH-1:0] opa,
  input  logic [DATA_WIDTH-1:0] opb,
  output logic                  prep_valid,
  output div_pkg::div_op_e      prep_op,
  output logic [DATA_WIDTH-1:0] dividend,
  output logic [DATA_WIDTH-1:0] divisor,
  output logic                  signed_op,
  output logic                  bypass
);
  import div_pkg::*;

  localparam logic [DATA_WIDTH-1:0] MOST_NEG = {1'b1, {(DATA_WIDTH-1){1'b0}}};

  logic is_signed;
  logic div_by_zero;
  logic overflow;

  assign is_signed   = (op == DIV_OP_DIV) || (op == DIV_OP_REM);
  assign div_by_zero = (opb == '0);
  // Most negative value divided by minus one.
  assign overflow    = is_signed && (opa == MOST_NEG) && (opb == '1);

  always_ff @(posedge clk) begin
    if (!nrst) begin
      prep_valid <= 1'b0;
    end else begin
      prep_valid <= start;
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      prep_op   <= op;
      dividend  <= opa;
      divisor   <= opb;
      signed_op <= is_signed;
      bypass    <= div_by_zero | overflow;
    end
  end

endmodule

/* hw/div_nonrestoring.sv */
// One quotient bit per cycle; divisor is never checked for zero, bypass items skip the loop.
`timescale 1ns/1ns

module div_nonrestoring #(
  parameter int DATA_WIDTH = div_pkg::DIV_DATA_WIDTH
) (
  input  logic                  clk,
  input  logic                  nrst,
  input  logic                  prep_valid,
  input  div_pkg::div_op_e      prep_op,
  input  logic [DATA_WIDTH-1:0] dividend,
  input  logic [DATA_WIDTH-1:0] divisor,
  input  logic                  signed_op,
  input  logic                  bypass,
  output logic                  core_valid,
  output div_pkg::div_op_e      core_op,
  output logic [DATA_WIDTH-1:0] core_dividend,
  output logic [DATA_WIDTH-1:0] core_divisor,
  output logic                  core_bypass,
  output logic [DATA_WIDTH-1:0] quotient,
  output logic [DATA_WIDTH-1:0] remainder
);
  import div_pkg::*;

  localparam int CNT_W = $clog2(DATA_WIDTH);

  div_state_e            state;
  logic [CNT_W-1:0]      count;
  logic [DATA_WIDTH-1:0] quo_q;
  logic [DATA_WIDTH:0]   rem_q;    // Partial remainder with one extra sign bit.
  logic                  sign_op_q;
  logic                  dvd_sign_q;
  logic                  dvd_sign_in;
  logic                  dvs_sign;
  logic [DATA_WIDTH:0]   dvs_ext;
  logic                  rem_sign;
  logic                  step_add;
  logic [DATA_WIDTH:0]   shifted;
  logic [DATA_WIDTH:0]   next_rem;
  logic                  last;
  logic [DATA_WIDTH-1:0] q_base;
  logic                  rem_nz;
  logic                  end_mismatch;
  logic                  fix_up;
  logic                  fix_down;

  assign dvd_sign_in = dividend[DATA_WIDTH-1] & signed_op;
  assign dvs_sign    = core_divisor[DATA_WIDTH-1] & sign_op_q;
  assign dvs_ext     = {dvs_sign, core_divisor};
  assign rem_sign    = rem_q[DATA_WIDTH];
  assign step_add    = rem_sign ^ dvs_sign; // Signs differ, so add back.
  assign shifted     = {rem_q[DATA_WIDTH-1:0], quo_q[DATA_WIDTH-1]};
  assign next_rem    = step_add ? shifted + dvs_ext : shifted - dvs_ext;
  assign last        = (count == CNT_W'(DATA_WIDTH - 1));

  // Final correction of the last quotient digit and the remainder.
  assign q_base       = {quo_q[DATA_WIDTH-2:0], 1'b1};
  assign rem_nz       = (rem_q != '0);
  assign end_mismatch = rem_nz && (rem_sign ^ dvd_sign_q); // Zero remainder is already exact.
  assign fix_up       = (rem_nz && rem_q == dvs_ext) || (end_mismatch && !step_add);
  assign fix_down     = (rem_nz && rem_q == -dvs_ext) || (end_mismatch && step_add);

  assign quotient  = fix_up   ? q_base + 1'b1 :
                     fix_down ? q_base - 1'b1 : q_base;
  assign remainder = fix_up   ? rem_q[DATA_WIDTH-1:0] - core_divisor :
                     fix_down ? rem_q[DATA_WIDTH-1:0] + core_divisor :
                                rem_q[DATA_WIDTH-1:0];

  always_ff @(posedge clk) begin
    if (!nrst) begin
      state      <= DIV_IDLE;
      count      <= '0;
      core_valid <= 1'b0;
    end else begin
      core_valid <= 1'b0;
      case (state)
        DIV_IDLE: begin
          if (prep_valid) begin
            count <= '0;
            if (bypass) core_valid <= 1'b1; // Result is formed downstream.
            else state <= DIV_BUSY;
          end
        end
        DIV_BUSY: begin
          count <= count + 1'b1;
          if (last) begin
            state      <= DIV_IDLE;
            core_valid <= 1'b1;
          end
        end
        default: state <= DIV_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == DIV_IDLE && prep_valid) begin
      core_op       <= prep_op;
      core_dividend <= dividend;
      core_divisor  <= divisor;
      core_bypass   <= bypass;
      sign_op_q     <= signed_op;
      dvd_sign_q    <= dvd_sign_in;
      quo_q         <= dividend;
      rem_q         <= {(DATA_WIDTH+1){dvd_sign_in}};
    end else if (state == DIV_BUSY) begin
      quo_q <= {quo_q[DATA_WIDTH-2:0], ~step_add};
      rem_q <= next_rem;
    end
  end

endmodule

/* hw/div_result_sel.sv */
// Last stage; a bypass item is zero divisor when the divisor is zero, otherwise signed overflow.
`timescale 1ns/1ns

module div_result_sel #(
  parameter int DATA_WIDTH = div_pkg::DIV_DATA_WIDTH
) (
  input  logic                  clk,
  input  logic                  nrst,
  input  logic                  core_valid,
  input  div_pkg::div_op_e      core_op,
  input  logic [DATA_WIDTH-1:0] core_dividend,
  input  logic [DATA_WIDTH-1:0] core_divisor,
  input  logic                  core_bypass,
  input  logic [DATA_WIDTH-1:0] quotient,
  input  logic [DATA_WIDTH-1:0] remainder,
  output logic                  res_valid,
  output logic [DATA_WIDTH-1:0] result
);
  import div_pkg::*;

  logic [DATA_WIDTH-1:0] sel_quo;
  logic [DATA_WIDTH-1:0] sel_rem;
  logic                  want_quo;

  always_comb begin
    sel_quo = quotient;
    sel_rem = remainder;
    if (core_bypass) begin
      if (core_divisor == '0) begin
        sel_quo = '1;             // All ones.
        sel_rem = core_dividend;
      end else begin
        sel_quo = core_dividend;  // Overflow wraps to the dividend.
        sel_rem = '0;
      end
    end
  end

  assign want_quo = (core_op == DIV_OP_DIV) || (core_op == DIV_OP_DIVU);

  always_ff @(posedge clk) begin
    if (!nrst) begin
      res_valid <= 1'b0;
    end else begin
      res_valid <= core_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (core_valid) result <= want_quo ? sel_quo : sel_rem;
  end

endmodule

/* hw/div_apb_top.sv */
// APB divide unit; pready is tied high and only one operation runs at a time.
`timescale 1ns/1ns

module div_apb_top #(
  parameter int DATA_WIDTH = div_pkg::DIV_DATA_WIDTH
) (
  input  logic                              clk,
  input  logic                              nrst,
  input  logic                              psel,
  input  logic                              penable,
  input  logic                              pwrite,
  input  logic [apb_pkg::APB_ADDR_WIDTH-1:0] paddr,
  input  logic [DATA_WIDTH-1:0]             pwdata,
  output logic [DATA_WIDTH-1:0]             prdata,
  output logic                              pready,
  output logic                              pslverr
);
  import div_pkg::*;

  logic                  start;
  div_op_e               op;
  logic [DATA_WIDTH-1:0] opa;
  logic [DATA_WIDTH-1:0] opb;

  logic                  prep_valid;
  div_op_e               prep_op;
  logic [DATA_WIDTH-1:0] dividend;
  logic [DATA_WIDTH-1:0] divisor;
  logic                  signed_op;
  logic                  bypass;

  logic                  core_valid;
  div_op_e               core_op;
  logic [DATA_WIDTH-1:0] core_dividend;
  logic [DATA_WIDTH-1:0] core_divisor;
  logic                  core_bypass;
  logic [DATA_WIDTH-1:0] quotient;
  logic [DATA_WIDTH-1:0] remainder;

  logic                  res_valid;
  logic [DATA_WIDTH-1:0] result;

  div_apb_regs #(.DATA_WIDTH(DATA_WIDTH)) i_regs (
    .clk(clk), .nrst(nrst), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .res_valid(res_valid), .result(result),
    .prdata(prdata), .pready(pready), .pslverr(pslverr), .start(start),
    .op(op), .opa(opa), .opb(opb)
  );

  div_operand_prep #(.DATA_WIDTH(DATA_WIDTH)) i_prep (
    .clk(clk), .nrst(nrst), .start(start), .op(op), .opa(opa), .opb(opb),
    .prep_valid(prep_valid), .prep_op(prep_op), .dividend(dividend),
    .divisor(divisor), .signed_op(signed_op), .bypass(bypass)
  );

  div_nonrestoring #(.DATA_WIDTH(DATA_WIDTH)) i_core (
    .clk(clk), .nrst(nrst), .prep_valid(prep_valid), .prep_op(prep_op),
    .dividend(dividend), .divisor(divisor), .signed_op(signed_op), .bypass(bypass),
    .core_valid(core_valid), .core_op(core_op), .core_dividend(core_dividend),
    .core_divisor(core_divisor), .core_bypass(core_bypass),
    .quotient(quotient), .remainder(remainder)
  );

  div_result_sel #(.DATA_WIDTH(DATA_WIDTH)) i_sel (
    .clk(clk), .nrst(nrst), .core_valid(core_valid), .core_op(core_op),
    .core_dividend(core_dividend), .core_divisor(core_divisor),
    .core_bypass(core_bypass), .quotient(quotient), .remainder(remainder),
    .res_valid(res_valid), .result(result)
  );

endmodule

/* verification/div_assert.sv */
// Bound into div_apb_top; checks are disabled in reset and latency assumes no pipeline stalls.
`timescale 1ns/1ns

module div_assert #(
  parameter int DATA_WIDTH = div_pkg::DIV_DATA_WIDTH
) (
  input logic                clk,
  input logic                nrst,
  input logic                psel,
  input logic                penable,
  input logic                pready,
  input logic                start,
  input logic                busy,
  input logic                prep_valid,
  input logic                bypass,
  input logic                core_valid,
  input div_pkg::div_state_e state
);
  import div_pkg::*;

  penable_needs_psel: assert property (@(posedge clk) disable iff (!nrst) penable |-> psel)
    else $error("penable high without psel");

  pready_high: assert property (@(posedge clk) disable iff (!nrst) pready)
    else $error("pready dropped low");

  // Busy has to cover every stage, so a start finds the whole pipeline empty.
  start_when_idle: assert property (@(posedge clk) disable iff (!nrst)
    start |-> !busy && state == DIV_IDLE && !prep_valid && !core_valid)
    else $error("start while busy");

  prep_into_idle_core: assert property (@(posedge clk) disable iff (!nrst)
    prep_valid |-> state == DIV_IDLE)
    else $error("prep_valid while core iterating");

  bypass_latency: assert property (@(posedge clk) disable iff (!nrst)
    prep_valid && bypass |=> core_valid)
    else $error("core_valid missing after bypass item");

  iterate_latency: assert property (@(posedge clk) disable iff (!nrst)
    prep_valid && !bypass |-> ##(DATA_WIDTH+1) core_valid) // One cycle per quotient bit.
    else $error("core_valid missing after iteration");

endmodule

bind div_apb_top div_assert #(.DATA_WIDTH(DATA_WIDTH)) i_assert (
  .clk(clk), .nrst(nrst), .psel(psel), .penable(penable), .pready(pready),
  .start(start), .busy(i_regs.busy), .prep_valid(prep_valid),
  .bypass(bypass), .core_valid(core_valid), .state(i_core.state)
);

/* verification/div_tb.sv */
// Default 32-bit width assumed; each operation is polled to STATUS done, so no latency is assumed.
`timescale 1ns/1ns

module div_tb;
  import div_pkg::*;
  import apb_pkg::*;

  localparam int W          = DIV_DATA_WIDTH;
  localparam int NUM_RAND   = 40;
  localparam int NUM_OPS    = NUM_RAND * 4 + 16;
  localparam int MAX_CYCLES = (NUM_OPS + 8) * (W + 30); // Writes, polling and read per op.
  localparam logic [W-1:0] MOST_NEG = {1'b1, {(W-1){1'b0}}};

  logic                      clk;
  logic                      nrst;
  logic                      psel;
  logic                      penable;
  logic                      pwrite;
  logic [APB_ADDR_WIDTH-1:0] paddr;
  logic [W-1:0]              pwdata;
  logic [W-1:0]              prdata;
  logic                      pready;
  logic                      pslverr;
  logic [31:0]               lcg_state;
  int                        cycles = 0;
  int                        test_errs = 0;
  int                        pass_cnt = 0;
  int                        fail_cnt = 0;

  div_apb_top #(.DATA_WIDTH(W)) i_dut (
    .clk(clk), .nrst(nrst), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: run did not complete within %0d cycles", MAX_CYCLES);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Expected result from the M-extension rules, special cases first.
  function automatic logic [W-1:0] ref_div(input div_op_e op, input logic [W-1:0] a,
                                           input logic [W-1:0] b);
    logic         sgn;
    logic [W-1:0] ma, mb, q, r;
    sgn = (op == DIV_OP_DIV) || (op == DIV_OP_REM);
    if (b == '0) begin
      q = '1;
      r = a;
    end else if (sgn && a == MOST_NEG && b == '1) begin
      q = a;
      r = '0;
    end else begin
      ma = (sgn && a[W-1]) ? -a : a; // Magnitudes, then fix signs.
      mb = (sgn && b[W-1]) ? -b : b;
      q  = ma / mb;
      r  = ma % mb;
      if (sgn && (a[W-1] ^ b[W-1])) q = -q;
      if (sgn && a[W-1]) r = -r;     // Remainder takes the dividend sign.
    end
    return (op == DIV_OP_DIV || op == DIV_OP_DIVU) ? q : r;
  endfunction

  task automatic check_result(input string name, input logic [W-1:0] exp,
                              input logic [W-1:0] act);
    if (act !== exp) begin
      $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
      test_errs++;
    end
  endtask

  task automatic check_err(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[FAIL] %s: expected pslverr %b, actual %b", name, exp, act);
      test_errs++;
    end
  endtask

  task automatic finish_test(input string name);
    if (test_errs == 0) begin
      pass_cnt++;
      $display("Test %s: passed", name);
    end else begin
      fail_cnt++;
      $display("Test %s: failed with %0d mismatches", name, test_errs);
    end
    test_errs = 0;
  endtask

  // Setup phase, access phase, then sample mid-cycle.
  task automatic apb_xfer(input logic wr, input logic [APB_ADDR_WIDTH-1:0] addr,
                          input logic [W-1:0] wdata, output logic [W-1:0] rdata,
                          output logic err);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_write(input logic [APB_ADDR_WIDTH-1:0] addr, input logic [W-1:0] data,
                           output logic err);
    logic [W-1:0] unused_rd;
    apb_xfer(1'b1, addr, data, unused_rd, err);
  endtask

  task automatic apb_read(input logic [APB_ADDR_WIDTH-1:0] addr, output logic [W-1:0] data,
                          output logic err);
    apb_xfer(1'b0, addr, '0, data, err);
  endtask

  task automatic wait_done();
    logic [W-1:0] status;
    logic         err;
    status = '0;
    while (!status[1]) apb_read(REG_STATUS, status, err); // Bit 1 is done.
  endtask

  task automatic run_and_check(input string name, input div_op_e op,
                               input logic [W-1:0] a, input logic [W-1:0] b);
    logic [W-1:0] res;
    logic         err;
    string        tag;
    tag = $sformatf("%s %s %h/%h", name, op.name(), a, b);
    apb_write(REG_OPA, a, err);
    apb_write(REG_OPB, b, err);
    apb_write(REG_CTRL, W'(op), err);
    check_err({tag, " start"}, 1'b0, err);
    wait_done();
    apb_read(REG_RESULT, res, err);
    check_err({tag, " read"}, 1'b0, err);
    check_result(tag, ref_div(op, a, b), res);
  endtask

  initial begin
    logic [W-1:0] data;
    logic         err;
    logic [W-1:0] a;
    logic [W-1:0] b;
    nrst      = 1'b0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    lcg_state = 32'h61c7;
    repeat (2) @(posedge clk);
    nrst <= 1'b1;

    apb_read(REG_STATUS, data, err);
    check_result("status after reset", '0, data);
    apb_read(REG_RESULT, data, err);
    check_err("result read before done", 1'b1, err);
    finish_test("reset");

    for (int i = 0; i < NUM_RAND; i++) begin
      lcg_state = lcg_next(lcg_state);
      a = W'(lcg_state);
      lcg_state = lcg_next(lcg_state);
      b = W'(lcg_state >> (i % 24)); // Spread of divisor magnitudes.
      for (int k = 0; k < 4; k++) run_and_check("random", div_op_e'(k), a, b);
    end
    // Odd exact quotient of a negative dividend leaves a zero remainder.
    for (int k = 0; k < 4; k++) run_and_check("exact", div_op_e'(k), -W'(91), W'(7));
    finish_test("random operands");

    lcg_state = lcg_next(lcg_state);
    a = W'(lcg_state);
    for (int k = 0; k < 4; k++) run_and_check("zero divisor", div_op_e'(k), a, '0);
    finish_test("zero divisor");

    for (int k = 0; k < 4; k++) run_and_check("overflow", div_op_e'(k), MOST_NEG, '1);
    finish_test("signed overflow");

    apb_write(REG_OPA, W'(100), err);
    apb_write(REG_OPB, W'(7), err);
    apb_write(REG_CTRL, W'(DIV_OP_DIV), err);
    apb_write(REG_CTRL, W'(DIV_OP_REMU), err);
    check_err("ctrl write while busy", 1'b1, err);
    apb_write(REG_OPA, W'(5), err);
    check_err("opa write while busy", 1'b1, err);
    apb_read(REG_OPA, data, err);
    check_result("opa after refused write", W'(100), data);
    wait_done();
    apb_read(REG_RESULT, data, err);
    check_result("result after refusals", ref_div(DIV_OP_DIV, W'(100), W'(7)), data);
    finish_test("busy refusal");

    apb_write(APB_ADDR_WIDTH'('h20), '0, err);
    check_err("unmapped write", 1'b1, err);
    apb_read(APB_ADDR_WIDTH'('h14), data, err);
    check_err("unmapped read", 1'b1, err);
    finish_test("unmapped address");

    $display("Tests passed: %0d, tests failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* compile.f */
hw/div_pkg.sv
hw/apb_pkg.sv
hw/div_apb_regs.sv
hw/div_operand_prep.sv
hw/div_nonrestoring.sv
hw/div_result_sel.sv
hw/div_apb_top.sv
verification/div_assert.sv
verification/div_tb.sv

/* Makefile */
OBJ_DIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module div_tb -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/Vdiv_tb | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf $(OBJ_DIR) sim.log
